//--- project.f
source/arena_pkg.sv
source/video_pkg.sv
source/arena_port_if.sv
source/game_config_apb.sv
source/arena_ram.sv
source/game_sequencer.sv
source/cycle_arena.sv
source/trail_scanner.sv
source/score_display.sv
source/light_cycle_top.sv
tests/tb_light_cycle.sv

//--- run.sh
#!/bin/sh
# compile and run the light cycle testbench with Verilator
set -e

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_light_cycle -o sim_light_cycle

./obj_dir/sim_light_cycle | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    exit 0
else
    exit 1
fi

//--- source/arena_pkg.sv
package arena_pkg;

    localparam int grid_w = 80;
    localparam int grid_h = 60;
    localparam int cell_count = grid_w * grid_h;

    typedef logic [12:0] cell_addr_t;   // x + y * grid_w
    typedef logic [6:0] cell_x_t;
    typedef logic [5:0] cell_y_t;

    typedef logic [1:0] cell_t;         // 0..2 player trail
    localparam cell_t cell_empty = 2'd3;

    // turning right adds one, left subtracts one
    typedef logic [1:0] dir_t;
    localparam dir_t dir_up = 2'd0;
    localparam dir_t dir_right = 2'd1;
    localparam dir_t dir_down = 2'd2;
    localparam dir_t dir_left = 2'd3;

    localparam int num_players = 3;
    localparam cell_x_t [num_players-1:0] start_x = {7'd45, 7'd35, 7'd40};
    localparam cell_y_t [num_players-1:0] start_y = {6'd35, 6'd35, 6'd25};
    localparam dir_t [num_players-1:0] start_dir = {dir_right, dir_left, dir_up};

    localparam int disp_ticks = 32;     // pause after a round

    localparam int tick_w = 24;
    localparam logic [tick_w-1:0] tick_period_rst = 24'd2_000_000;
    localparam logic [tick_w-1:0] tick_period_min = 24'd32;
    localparam logic [num_players-1:0] player_mask_rst = 3'b111;
    localparam logic [3:0] reg_tick = 4'h0;
    localparam logic [3:0] reg_mask = 4'h4;

    localparam logic [1:0] seq_idle = 2'd0;
    localparam logic [1:0] seq_game = 2'd1;
    localparam logic [1:0] seq_disp = 2'd2;

    localparam logic [3:0] step_write = 4'd10;  // first trail write clock
    localparam logic [3:0] step_move = 4'd13;

endpackage

//--- source/arena_port_if.sv
interface arena_port_if;
    import arena_pkg::*;

    cell_addr_t addr;
    cell_t wdata;
    logic wren;
    cell_t rdata;   // registered in the memory

    modport user (
        output addr, wdata, wren,
        input rdata
    );

    modport mem (
        input addr, wdata, wren,
        output rdata
    );

endinterface

//--- source/arena_ram.sv
module arena_ram (
    input logic CLOCK_50,
    arena_port_if.mem ram_a,
    arena_port_if.mem ram_b
);
    import arena_pkg::*;

    cell_t mem [cell_count];

    always_ff @(posedge CLOCK_50) begin
        if (ram_b.wren)
            mem[ram_b.addr] <= ram_b.wdata;
        // port a is written last so it wins on the same cell
        if (ram_a.wren)
            mem[ram_a.addr] <= ram_a.wdata;
    end

    // read old contents, one clock latency
    always_ff @(posedge CLOCK_50) begin
        ram_a.rdata <= mem[ram_a.addr];
        ram_b.rdata <= mem[ram_b.addr];
    end

endmodule

//--- source/cycle_arena.sv
module cycle_arena (
    input  logic CLOCK_50,
    input  logic game_tick,
    input  logic clearing,
    input  logic running,
    input  logic [arena_pkg::num_players-1:0] turn_left,
    input  logic [arena_pkg::num_players-1:0] turn_right,
    input  logic [arena_pkg::num_players-1:0] player_mask,
    output logic arena_clear,
    output logic round_over,
    output logic [arena_pkg::num_players-1:0] alive,
    arena_port_if.user ram_a
);
    import arena_pkg::*;

    cell_addr_t clr_cnt;
    cell_x_t px [num_players];
    cell_y_t py [num_players];
    dir_t heading [num_players];
    logic [num_players-1:0] entrants;
    logic [3:0] step;       // 0 waits for a tick, 1..13 run the step
    logic [1:0] sel;
    logic off_grid;
    logic check_clk;
    logic [1:0] n_alive;
    logic [1:0] n_entrants;

    assign arena_clear = (clr_cnt == cell_addr_t'(cell_count));

    // player owning the current phase
    always_comb begin
        if (step >= step_write && step < step_move)
            sel = 2'(step - step_write);
        else if (step >= 4'd7)
            sel = 2'd2;
        else if (step >= 4'd4)
            sel = 2'd1;
        else
            sel = 2'd0;
    end

    // wrapped coordinates land past the edge too
    assign off_grid = (px[sel] >= cell_x_t'(grid_w)) || (py[sel] >= cell_y_t'(grid_h));
    assign check_clk = (step == 4'd3) || (step == 4'd6) || (step == 4'd9);

    always_comb begin
        n_alive = '0;
        n_entrants = '0;
        for (int p = 0; p < num_players; p++) begin
            n_alive += 2'(alive[p]);
            n_entrants += 2'(entrants[p]);
        end
    end

    // a lone entrant plays until it crashes
    assign round_over = (n_alive == 2'd0) || (n_alive == 2'd1 && n_entrants > 2'd1);

    always_comb begin
        ram_a.addr = cell_addr_t'(px[sel]) + cell_addr_t'(py[sel]) * cell_addr_t'(grid_w);
        ram_a.wdata = cell_t'(sel);
        ram_a.wren = running && step >= step_write && step < step_move && alive[sel];
        if (clearing) begin
            ram_a.addr = clr_cnt;
            ram_a.wdata = cell_empty;
            ram_a.wren = !arena_clear;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (clearing) begin
            if (!arena_clear)
                clr_cnt <= clr_cnt + 1'b1;
            alive <= player_mask;
            entrants <= player_mask;
            step <= '0;
            for (int p = 0; p < num_players; p++) begin
                px[p] <= start_x[p];
                py[p] <= start_y[p];
                heading[p] <= start_dir[p];
            end
        end else begin
            clr_cnt <= '0;
            if (!running) begin
                step <= '0;
            end else if (step == '0) begin
                if (game_tick) begin
                    step <= 4'd1;
                    for (int p = 0; p < num_players; p++) begin
                        if (turn_right[p] && !turn_left[p])
                            heading[p] <= heading[p] + 1'b1;
                        else if (turn_left[p] && !turn_right[p])
                            heading[p] <= heading[p] - 1'b1;
                    end
                end
            end else begin
                step <= (step == step_move) ? '0 : step + 1'b1;
                if (check_clk && alive[sel] && (off_grid || ram_a.rdata != cell_empty))
                    alive[sel] <= 1'b0;     // crash
                if (step == step_move) begin
                    for (int p = 0; p < num_players; p++) begin
                        if (alive[p]) begin
                            case (heading[p])
                                dir_up: py[p] <= py[p] - 1'b1;
                                dir_right: px[p] <= px[p] + 1'b1;
                                dir_down: py[p] <= py[p] + 1'b1;
                                default: px[p] <= px[p] - 1'b1;
                            endcase
                        end
                    end
                end
            end
        end
    end

endmodule

//--- source/game_config_apb.sv
module game_config_apb (
    input  logic CLOCK_50,
    input  logic reset_game,
    input  logic [3:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [31:0] pwdata,
    input  logic game_tick,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic [arena_pkg::tick_w-1:0] tick_period,
    output logic [arena_pkg::num_players-1:0] player_mask
);
    import arena_pkg::*;

    logic [tick_w-1:0] tick_stage;
    logic [num_players-1:0] mask_stage;
    logic addr_ok;
    logic wr_en;

    assign addr_ok = (paddr == reg_tick) || (paddr == reg_mask);
    assign wr_en = psel && penable && pwrite && addr_ok;
    assign pready = 1'b1;   // no wait states
    assign pslverr = psel && penable && !addr_ok;

    always_comb begin
        prdata = '0;
        if (paddr == reg_tick)
            prdata = 32'(tick_stage);
        else if (paddr == reg_mask)
            prdata = 32'(mask_stage);
    end

    always_ff @(posedge CLOCK_50) begin
        if (reset_game) begin
            tick_stage <= tick_period_rst;
            mask_stage <= player_mask_rst;
            tick_period <= tick_period_rst;
            player_mask <= player_mask_rst;
        end else begin
            if (wr_en && paddr == reg_tick)
                tick_stage <= (pwdata < 32'(tick_period_min)) ? tick_period_min
                                                              : pwdata[tick_w-1:0];
            if (wr_en && paddr == reg_mask)
                mask_stage <= pwdata[num_players-1:0];
            if (game_tick) begin    // staged values go live on the tick
                tick_period <= tick_stage;
                player_mask <= mask_stage;
            end
        end
    end

endmodule

//--- source/game_sequencer.sv
module game_sequencer (
    input  logic CLOCK_50,
    input  logic reset_game,
    input  logic [arena_pkg::tick_w-1:0] tick_period,
    input  logic start,
    input  logic arena_clear,
    input  logic round_over,
    output logic game_tick,
    output logic clearing,
    output logic running,
    output logic round_end
);
    import arena_pkg::*;

    logic [tick_w-1:0] tick_cnt;
    logic [1:0] state;
    logic [1:0] state_next;
    logic [5:0] disp_cnt;

    always_ff @(posedge CLOCK_50) begin
        if (reset_game) begin
            tick_cnt <= '0;
            game_tick <= 1'b0;
        end else if (tick_cnt >= tick_period - 1'b1) begin  // >= in case the period shrank
            tick_cnt <= '0;
            game_tick <= 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            game_tick <= 1'b0;
        end
    end

    always_comb begin
        state_next = state;
        if (game_tick) begin
            case (state)
                seq_idle: if (start && arena_clear) state_next = seq_game;
                seq_game: if (round_over) state_next = seq_disp;
                default: if (disp_cnt == 6'(disp_ticks - 1)) state_next = seq_idle;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (reset_game) begin
            state <= seq_idle;
            clearing <= 1'b0;
            running <= 1'b0;
            round_end <= 1'b0;
            disp_cnt <= '0;
        end else begin
            state <= state_next;
            clearing <= (state_next == seq_idle);
            running <= (state_next == seq_game);
            round_end <= (state == seq_game) && (state_next == seq_disp);
            if (state != seq_disp)
                disp_cnt <= '0;
            else if (game_tick)
                disp_cnt <= disp_cnt + 1'b1;
        end
    end

endmodule

//--- source/light_cycle_top.sv
module light_cycle_top (
    input  logic CLOCK_50,
    input  logic reset_game,
    input  logic start,
    input  logic [2:0] turn_left,
    input  logic [2:0] turn_right,
    input  logic [3:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic [7:0] x,
    output logic [6:0] y,
    output logic [5:0] colour,
    output logic plot,
    output logic [2:0] alive,
    output logic [6:0] hex0,
    output logic [6:0] hex1,
    output logic [6:0] hex2,
    output logic [6:0] hex3,
    output logic [6:0] hex4,
    output logic [6:0] hex5
);

    logic [23:0] tick_period;
    logic [2:0] player_mask;
    logic game_tick;
    logic clearing;
    logic running;
    logic round_end;
    logic arena_clear;
    logic round_over;

    arena_port_if port_a ();    // game logic
    arena_port_if port_b ();    // scanner

    game_config_apb u_config (
        .CLOCK_50(CLOCK_50), .reset_game(reset_game),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .game_tick(game_tick),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .tick_period(tick_period), .player_mask(player_mask)
    );

    game_sequencer u_sequencer (
        .CLOCK_50(CLOCK_50), .reset_game(reset_game), .tick_period(tick_period),
        .start(start), .arena_clear(arena_clear), .round_over(round_over),
        .game_tick(game_tick), .clearing(clearing), .running(running), .round_end(round_end)
    );

    cycle_arena u_arena (
        .CLOCK_50(CLOCK_50), .game_tick(game_tick), .clearing(clearing), .running(running),
        .turn_left(turn_left), .turn_right(turn_right), .player_mask(player_mask),
        .arena_clear(arena_clear), .round_over(round_over), .alive(alive),
        .ram_a(port_a.user)
    );

    arena_ram u_ram (
        .CLOCK_50(CLOCK_50), .ram_a(port_a.mem), .ram_b(port_b.mem)
    );

    trail_scanner u_scanner (
        .CLOCK_50(CLOCK_50), .reset_game(reset_game), .alive(alive),
        .x(x), .y(y), .colour(colour), .plot(plot),
        .ram_b(port_b.user)
    );

    score_display u_score (
        .CLOCK_50(CLOCK_50), .reset_game(reset_game), .round_end(round_end), .alive(alive),
        .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
    );

endmodule

//--- source/score_display.sv
module score_display (
    input  logic CLOCK_50,
    input  logic reset_game,
    input  logic round_end,
    input  logic [arena_pkg::num_players-1:0] alive,
    output video_pkg::seg_t hex0,
    output video_pkg::seg_t hex1,
    output video_pkg::seg_t hex2,
    output video_pkg::seg_t hex3,
    output video_pkg::seg_t hex4,
    output video_pkg::seg_t hex5
);
    import arena_pkg::*;
    import video_pkg::*;

    logic [6:0] score [num_players];
    seg_t seg_tens [num_players];
    seg_t seg_units [num_players];

    always_ff @(posedge CLOCK_50) begin
        if (reset_game) begin
            for (int p = 0; p < num_players; p++)
                score[p] <= '0;
        end else if (round_end) begin
            for (int p = 0; p < num_players; p++) begin
                if (alive[p])
                    score[p] <= (score[p] == 7'd99) ? '0 : score[p] + 1'b1;  // wraps at 100
            end
        end
    end

    always_comb begin
        for (int p = 0; p < num_players; p++) begin
            seg_tens[p] = seg_digits[4'(score[p] / 7'd10)];
            seg_units[p] = seg_digits[4'(score[p] % 7'd10)];
        end
    end

    // player 0 on the left pair
    assign hex5 = seg_tens[0];
    assign hex4 = seg_units[0];
    assign hex3 = seg_tens[1];
    assign hex2 = seg_units[1];
    assign hex1 = seg_tens[2];
    assign hex0 = seg_units[2];

endmodule

//--- source/trail_scanner.sv
module trail_scanner (
    input  logic CLOCK_50,
    input  logic reset_game,
    input  logic [arena_pkg::num_players-1:0] alive,
    output logic [$clog2(video_pkg::screen_w)-1:0] x,
    output logic [$clog2(video_pkg::screen_h)-1:0] y,
    output video_pkg::colour_t colour,
    output logic plot,
    arena_port_if.user ram_b
);
    import arena_pkg::*;
    import video_pkg::*;

    cell_x_t cx;
    cell_y_t cy;
    logic [2:0] phase;      // 0-1 fetch, 2-5 plot
    cell_t cell_q;
    logic live;
    logic owner_dead;

    assign live = (cell_q != cell_empty) && alive[cell_q];
    assign owner_dead = (cell_q != cell_empty) && !alive[cell_q];

    assign plot = (phase >= 3'd2);
    assign x = {cx, (phase == 3'd3) || (phase == 3'd5)};
    assign y = {cy, (phase == 3'd4) || (phase == 3'd5)};
    assign colour = live ? player_colour[cell_q] : empty_colour;

    // dead trails are wiped while they are drawn
    assign ram_b.addr = cell_addr_t'(cx) + cell_addr_t'(cy) * cell_addr_t'(grid_w);
    assign ram_b.wdata = cell_empty;
    assign ram_b.wren = plot && owner_dead;

    always_ff @(posedge CLOCK_50) begin
        if (reset_game) begin
            phase <= '0;
            cx <= cell_x_t'(grid_w - 1);
            cy <= cell_y_t'(grid_h - 1);
        end else if (phase == 3'd5) begin
            phase <= '0;
            if (cx == '0) begin
                cx <= cell_x_t'(grid_w - 1);
                cy <= (cy == '0) ? cell_y_t'(grid_h - 1) : cy - 1'b1;
            end else begin
                cx <= cx - 1'b1;
            end
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // code held for all four pixels
    always_ff @(posedge CLOCK_50) begin
        if (phase == 3'd1)
            cell_q <= ram_b.rdata;
    end

endmodule

//--- source/video_pkg.sv
package video_pkg;

    localparam int screen_w = 160;
    localparam int screen_h = 120;

    // rrggbb
    typedef logic [5:0] colour_t;
    localparam colour_t [2:0] player_colour = {6'b111000, 6'b001100, 6'b011111};
    localparam colour_t empty_colour = 6'b000001;

    // active low, bit 0 is segment a
    typedef logic [6:0] seg_t;
    localparam seg_t [9:0] seg_digits = {
        7'b0010000, 7'b0000000, 7'b1111000, 7'b0000010, 7'b0010010,
        7'b0011001, 7'b0110000, 7'b0100100, 7'b1111001, 7'b1000000
    };

endpackage

//--- tests/tb_light_cycle.sv
module tb_light_cycle;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int tick_len = 1000;     // tick period used after the first test
    localparam int full_scan = 19200;   // 4800 cells, 4 pixels each

    logic CLOCK_50;
    logic reset_game;
    logic start;
    logic [2:0] turn_left;
    logic [2:0] turn_right;
    logic [3:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic [7:0] x;
    logic [6:0] y;
    logic [5:0] colour;
    logic plot;
    logic [2:0] alive;
    logic [6:0] hex0, hex1, hex2, hex3, hex4, hex5;

    int errors;
    int checks;
    int failed_tests;
    int test_num;
    int test_err0;
    int plot_checks;
    int trail_plots;
    int align_cnt;
    bit check_en;
    logic [5:0] exp_colour;

    // grid model
    logic [1:0] grid [4800];
    int mx [3];
    int my [3];
    int mh [3];
    logic [2:0] m_alive;
    logic [2:0] m_entrants;
    bit m_over;
    int m_steps;
    int p0_death_step;
    int exp_score [3];

    light_cycle_top DUT (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    function automatic logic [6:0] digit_seg(input int d);
        case (d)    // gfedcba, low lights a segment
            0: return 7'b1000000;
            1: return 7'b1111001;
            2: return 7'b0100100;
            3: return 7'b0110000;
            4: return 7'b0011001;
            5: return 7'b0010010;
            6: return 7'b0000010;
            7: return 7'b1111000;
            8: return 7'b0000000;
            default: return 7'b0010000;
        endcase
    endfunction

    function automatic logic [13:0] ref_seg(input int score);
        return {digit_seg(score / 10), digit_seg(score % 10)};
    endfunction

    function automatic logic [5:0] ref_cell_colour(input logic [1:0] code, input logic [2:0] live);
        if (code == 2'd3 || !live[code])
            return 6'b000001;
        case (code)
            2'd0: return 6'b011111;
            2'd1: return 6'b001100;
            default: return 6'b111000;
        endcase
    endfunction

    function automatic int cell_index(input int cx, input int cy);
        return cx + cy * 80;
    endfunction

    function automatic bit off_grid(input int p);
        return mx[p] < 0 || mx[p] >= 80 || my[p] < 0 || my[p] >= 60;
    endfunction

    function void model_init(input logic [2:0] mask);
        for (int i = 0; i < 4800; i++)
            grid[i] = 2'd3;
        mx = '{40, 35, 45};
        my = '{25, 35, 35};
        mh = '{0, 3, 1};    // up, left, right
        m_alive = mask;
        m_entrants = mask;
        m_over = 1'b0;
        m_steps = 0;
        p0_death_step = 0;
    endfunction

    // one game tick: turns, checks, trail writes, moves
    function void model_step();
        int n_alive;
        int n_ent;
        n_alive = 0;
        n_ent = 0;
        for (int p = 0; p < 3; p++) begin
            if (turn_right[p] && !turn_left[p])
                mh[p] = (mh[p] + 1) % 4;
            else if (turn_left[p] && !turn_right[p])
                mh[p] = (mh[p] + 3) % 4;
        end
        for (int p = 0; p < 3; p++)
            if (m_alive[p] && (off_grid(p) || grid[cell_index(mx[p], my[p])] != 2'd3))
                m_alive[p] = 1'b0;
        for (int p = 0; p < 3; p++)
            if (m_alive[p])
                grid[cell_index(mx[p], my[p])] = 2'(p);  // later player wins a shared cell
        for (int p = 0; p < 3; p++) begin
            if (m_alive[p]) begin
                case (mh[p])
                    0: my[p]--;
                    1: mx[p]++;
                    2: my[p]++;
                    default: mx[p]--;
                endcase
            end
            n_alive += int'(m_alive[p]);
            n_ent += int'(m_entrants[p]);
        end
        m_over = (n_alive == 0) || (n_alive == 1 && n_ent > 1);
        m_steps++;
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    always @(posedge CLOCK_50) begin
        if (DUT.game_tick && DUT.running && !m_over) begin
            model_step();
            align_cnt = 16;     // step is over well before this
        end else if (align_cnt > 0) begin
            align_cnt--;
            if (align_cnt == 0) begin
                checks++;
                assert (alive == m_alive)
                else report_mismatch($sformatf("alive %b, expected %b", alive, m_alive));
                if (!alive[0] && p0_death_step == 0)
                    p0_death_step = m_steps;
            end
        end
        if (DUT.round_end)
            for (int p = 0; p < 3; p++)
                if (m_alive[p])
                    exp_score[p] = (exp_score[p] + 1) % 100;
    end

    // pixel checker, only while the grid is frozen
    always @(posedge CLOCK_50) begin
        if (check_en && plot && !DUT.running && (!DUT.clearing || DUT.arena_clear)) begin
            exp_colour = ref_cell_colour(grid[cell_index(x[7:1], y[6:1])], m_alive);
            plot_checks++;
            if (colour != 6'b000001)
                trail_plots++;
            assert (colour == exp_colour)
            else report_mismatch($sformatf("pixel (%0d,%0d) colour %b, expected %b",
                                           x, y, colour, exp_colour));
        end
    end

    function automatic bit probe(input int which);
        case (which)
            0: return DUT.game_tick;
            1: return DUT.running;
            2: return DUT.round_end;
            3: return DUT.clearing;
            default: return DUT.arena_clear;
        endcase
    endfunction

    task automatic wait_for(input int which, input int limit, input string what, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < limit && !ok; n++) begin
            @(posedge CLOCK_50);
            ok = probe(which);
        end
        if (!ok) begin
            errors++;
            $display("timeout after %0d cycles waiting for %s", limit, what);
        end
    endtask

    task automatic apb_access(input bit wr, input logic [3:0] addr, input logic [31:0] data,
                              output logic [31:0] rd, output logic err);
        @(posedge CLOCK_50);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= data;
        @(posedge CLOCK_50);
        penable <= 1'b1;
        @(posedge CLOCK_50);
        rd = prdata;
        err = pslverr;
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic err;
        apb_access(1'b1, addr, data, rd, err);
    endtask

    task automatic check_read(input logic [3:0] addr, input logic [31:0] expected);
        logic [31:0] rd;
        logic err;
        apb_access(1'b0, addr, 32'd0, rd, err);
        checks++;
        assert (rd == expected && !err && pready)
        else report_mismatch($sformatf("read 0x%0h gave %0d err %b ready %b, expected %0d",
                                       addr, rd, err, pready, expected));
    endtask

    task automatic begin_test(input string name);
        test_num++;
        test_err0 = errors;
        $display("test %0d %s started", test_num, name);
    endtask

    task automatic end_test(input string name);
        if (errors != test_err0)
            failed_tests++;
        $display("test %0d %s: %s", test_num, name, (errors == test_err0) ? "ok" : "failed");
    endtask

    task automatic check_scores();
        logic [13:0] e;
        e = ref_seg(exp_score[0]);
        checks++;
        assert ({hex5, hex4} == e) else report_mismatch("player 0 score digits");
        e = ref_seg(exp_score[1]);
        assert ({hex3, hex2} == e) else report_mismatch("player 1 score digits");
        e = ref_seg(exp_score[2]);
        assert ({hex1, hex0} == e) else report_mismatch("player 2 score digits");
    endtask

    // mode 0 no turns, 1 random turns, 2 steer player 1 into player 2
    task automatic run_round(input logic [2:0] mask, input int mode);
        bit ok;
        int k;
        int r;
        logic [2:0] tl;
        logic [2:0] tr;
        apb_write(4'h4, 32'(mask));
        wait_for(0, tick_len + 10, "mask update tick", ok);
        repeat (2) @(posedge CLOCK_50);
        checks++;
        assert (alive == mask) else report_mismatch($sformatf("alive %b before start", alive));
        model_init(mask);
        turn_left <= 3'b000;
        turn_right <= (mode == 2) ? 3'b010 : 3'b000;   // first step turns up
        start <= 1'b1;
        wait_for(1, 10 * tick_len, "round start", ok);
        start <= 1'b0;
        k = 0;
        while (ok && !m_over && k < 400) begin
            wait_for(0, tick_len + 10, "game tick", ok);
            @(posedge CLOCK_50);
            k++;
            tl = 3'b000;
            tr = 3'b000;
            for (int p = 1; p < 3; p++) begin
                r = $urandom % 8;
                if (mode == 1 && mask[p] && r == 0)
                    tl[p] = 1'b1;
                else if (mode == 1 && mask[p] && r == 1)
                    tr[p] = 1'b1;
            end
            if (mode == 2 && (k + 1 == 2 || k + 1 == 17))
                tr = 3'b010;
            turn_left <= tl;
            turn_right <= tr;
        end
        if (!m_over) begin
            errors++;
            $display("round did not finish within %0d ticks", k);
        end
        wait_for(2, 2 * tick_len + 10, "round end", ok);
        turn_left <= 3'b000;
        turn_right <= 3'b000;
        repeat (2) @(posedge CLOCK_50);
    endtask

    task automatic display_window();
        bit ok;
        int c0;
        c0 = plot_checks;
        trail_plots = 0;
        check_en <= 1'b1;
        wait_for(3, 40 * tick_len, "return to idle", ok);
        check_en <= 1'b0;
        checks++;
        assert (plot_checks - c0 >= full_scan)
        else report_mismatch($sformatf("only %0d pixels checked", plot_checks - c0));
    endtask

    initial begin
        bit ok;
        int c0;
        start = 1'b0;
        turn_left = 3'b000;
        turn_right = 3'b000;
        paddr = 4'h0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = 32'd0;
        reset_game = 1'b1;
        errors = 0;
        checks = 0;
        failed_tests = 0;
        test_num = 0;
        plot_checks = 0;
        trail_plots = 0;
        align_cnt = 0;
        check_en = 1'b0;
        exp_score = '{0, 0, 0};
        void'($urandom(39));
        model_init(3'b111);
        repeat (16) @(posedge CLOCK_50);
        reset_game <= 1'b0;

        begin_test("apb registers");
        check_read(4'h0, 32'd2_000_000);
        check_read(4'h4, 32'd7);
        apb_write(4'h0, 32'd64);
        check_read(4'h0, 32'd64);
        apb_write(4'h0, 32'd5);
        check_read(4'h0, 32'd32);   // clamped to the minimum
        begin
            logic [31:0] rd;
            logic err;
            apb_access(1'b0, 4'h8, 32'd0, rd, err);
            checks++;
            assert (err) else report_mismatch("no pslverr for address 8");
        end
        apb_write(4'h0, 32'(tick_len));
        end_test("apb registers");

        begin_test("clearing");
        wait_for(0, 2_100_000, "first game tick", ok);
        wait_for(4, 6000, "arena clear", ok);
        checks++;
        assert (alive == 3'b111) else report_mismatch($sformatf("alive %b after clear", alive));
        c0 = plot_checks;
        check_en <= 1'b1;
        repeat (29000) @(posedge CLOCK_50);     // one full scan
        check_en <= 1'b0;
        @(posedge CLOCK_50);
        assert (plot_checks - c0 >= full_scan) else report_mismatch("scan incomplete");
        end_test("clearing");

        begin_test("wall death");
        run_round(3'b001, 0);
        checks++;
        assert (p0_death_step == 27)
        else report_mismatch($sformatf("player 0 died at step %0d", p0_death_step));
        assert (alive == 3'b000) else report_mismatch("player 0 still alive");
        check_scores();
        display_window();
        end_test("wall death");

        begin_test("collision and scoring");
        run_round(3'b110, 2);
        checks++;
        assert (alive == 3'b100 && m_alive == 3'b100)
        else report_mismatch($sformatf("alive %b after collision", alive));
        assert (exp_score[2] == 1) else report_mismatch("player 2 score not one");
        check_scores();
        display_window();
        end_test("collision and scoring");

        begin_test("trails and colours");
        run_round(3'b110, 1);
        check_scores();
        display_window();
        if (m_alive != 3'b000) begin
            checks++;
            assert (trail_plots > 0) else report_mismatch("survivor trail never drawn");
        end
        end_test("trails and colours");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d pixels, %0d errors",
                 test_num, failed_tests, checks, plot_checks, errors);
        if (errors == 0 && failed_tests == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
